// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_mmio_ep_out
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
usb_ep_pkg.sv
mmio_cmd_pkg.sv
frame_byte_counter.sv
mmio_cmd_parser.sv
mmio_ep_ctrl.sv
packet_fifo.sv
mmio_ep_out.sv
tb_clock_gen.sv
tb_mmio_ep_out.sv

// ==== frame_byte_counter.sv ====
module frame_byte_counter (
  input  logic                        clock,
  input  logic                        rst_n_i,
  input  logic                        clear_i,
  input  logic                        beat_i,
  input  logic                        tkeep_i,
  input  logic                        tlast_i,
  input  logic [usb_ep_pkg::cnt_w:0]  max_size_i,
  output usb_ep_pkg::frame_evt_t      evt_o
);
  import usb_ep_pkg::*;

  logic [cnt_w-1:0] idx_q;
  logic [cnt_w:0]   next_len;

  // Frame length if the current byte turns out to be the last
  assign next_len = {1'b0, idx_q} + 1'b1;

  // Events are combinational, so users react on the handshake edge itself
  always_comb begin
    evt_o.beat      = beat_i & tkeep_i;
    evt_o.last      = beat_i & tlast_i;
    evt_o.zdp       = beat_i & tlast_i & ~tkeep_i;
    evt_o.short_frm = beat_i & tkeep_i & tlast_i & (next_len < max_size_i);
    evt_o.idx       = idx_q;
  end

  // Index restarts after every frame end, ZDP included
  always_ff @(posedge clock) begin
    if (!rst_n_i || clear_i) begin
      idx_q <= '0;
    end else if (beat_i && tlast_i) begin
      idx_q <= '0;
    end else if (beat_i && tkeep_i) begin
      idx_q <= idx_q + 1'b1;
    end
  end

endmodule

// ==== mmio_cmd_parser.sv ====
module mmio_cmd_parser (
  input  logic                    clock,
  input  logic                    rst_n_i,
  input  logic                    clear_i,
  input  logic                    enable_i,
  input  logic [7:0]              usb_tdata_i,
  input  usb_ep_pkg::frame_evt_t  evt_i,
  output logic                    tready_o,
  output mmio_cmd_pkg::mmio_cmd_t cmd_o,
  output logic                    cmd_vld_o,
  input  logic                    cmd_ack_i,
  input  logic                    resp_i,
  output logic                    store_o,
  output logic                    malformed_o
);
  import usb_ep_pkg::*;
  import mmio_cmd_pkg::*;

  parse_state_e state;
  logic [31:0]  sreg;
  logic [31:0]  shifted;
  logic         parsing;
  logic         at_magic, at_addr, at_word, at_idop;

  // Bytes arrive LSB first, so shift in from the top
  assign shifted = {usb_tdata_i, sreg[31:8]};

  assign parsing = (state inside {ps_idle, ps_magic, ps_addr, ps_word, ps_idop});
  assign tready_o = enable_i && parsing;
  assign malformed_o = (state == ps_halt);

  // Field boundaries, only valid in the matching phase
  assign at_magic = evt_i.beat && (state == ps_magic) && (evt_i.idx == cnt_w'(magic_end_idx));
  assign at_addr = evt_i.beat && (state == ps_addr) && (evt_i.idx == cnt_w'(addr_end_idx));
  assign at_word = evt_i.beat && (state == ps_word) && (evt_i.idx == cnt_w'(word_end_idx));
  assign at_idop = evt_i.beat && (state == ps_idop) &&
                   (evt_i.idx == cnt_w'(cmd_len_bytes - 1));

  always_ff @(posedge clock) begin
    if (!rst_n_i || clear_i) begin
      state     <= ps_idle;
      cmd_vld_o <= 1'b0;
      store_o   <= 1'b0;
    end else begin
      store_o <= 1'b0;
      if (cmd_ack_i || resp_i) begin
        cmd_vld_o <= 1'b0;
      end
      case (state)
        // Any frame end before the opcode byte is malformed
        ps_idle: if (evt_i.last) state <= ps_halt;
                 else if (evt_i.beat) state <= ps_magic;
        ps_magic: if (evt_i.last || (at_magic && shifted != cmd_magic)) state <= ps_halt;
                  else if (at_magic) state <= ps_addr;
        ps_addr: if (evt_i.last) state <= ps_halt;
                 else if (at_addr) state <= ps_word;
        ps_word: if (evt_i.last) state <= ps_halt;
                 else if (at_word) state <= ps_idop;
        // Byte 10 must carry tlast, anything else stalls
        ps_idop: begin
          if (at_idop && evt_i.last) begin
            state     <= ps_busy;
            cmd_vld_o <= 1'b1;
            store_o   <= (cmd_op_e'(usb_tdata_i[1:0]) == op_store) && !usb_tdata_i[3];
          end else if (at_idop || evt_i.last) begin
            state <= ps_halt;
          end
        end
        // Held while the MMIO side runs the command
        ps_busy: if (resp_i) state <= ps_idle;
        // Only a configuration event leaves HALT
        default: state <= ps_halt;
      endcase
    end
  end

  // Field capture, payload only
  always_ff @(posedge clock) begin
    if (evt_i.beat && parsing) begin
      sreg <= shifted;
    end
    if (at_addr) begin
      {cmd_o.lun, cmd_o.adr} <= shifted;
    end
    if (at_word) begin
      cmd_o.len <= shifted[31:16];
    end
    if (at_idop) begin
      cmd_o.tag <= usb_tdata_i[7:4];
      cmd_o.dir <= usb_tdata_i[3];
      cmd_o.apb <= usb_tdata_i[2];
      cmd_o.op  <= cmd_op_e'(usb_tdata_i[1:0]);
    end
  end

endmodule

// ==== mmio_cmd_pkg.sv ====
package mmio_cmd_pkg;

  // Command opcodes, from the low two bits of the last command byte
  typedef enum logic [1:0] {
    op_store = 2'd0,
    op_fetch = 2'd1,
    op_set   = 2'd2,
    op_get   = 2'd3
  } cmd_op_e;

  // Parser phases
  typedef enum logic [2:0] {
    ps_idle  = 3'd0,
    ps_magic = 3'd1,
    ps_addr  = 3'd2,
    ps_word  = 3'd3,
    ps_idop  = 3'd4,
    ps_busy  = 3'd5,
    ps_halt  = 3'd6
  } parse_state_e;

  // "TART", first byte received sits in bits 7:0
  localparam logic [31:0] cmd_magic = {8'h54, 8'h52, 8'h41, 8'h54};

  // Command packet layout, by byte index within the frame
  localparam int unsigned cmd_len_bytes = 11;
  localparam int unsigned magic_end_idx = 3;
  localparam int unsigned addr_end_idx = 7;
  localparam int unsigned word_end_idx = 9;

  // Decoded command, last packet byte in the top eight bits
  typedef struct packed {
    logic [3:0]  tag;
    logic        dir;
    logic        apb;
    cmd_op_e     op;
    logic [3:0]  lun;
    logic [27:0] adr;
    logic [15:0] len;
  } mmio_cmd_t;

endpackage

// ==== mmio_ep_ctrl.sv ====
module mmio_ep_ctrl (
  input  logic                         clock,
  input  logic                         rst_n_i,
  input  logic                         set_conf_i,
  input  logic                         clr_conf_i,
  input  logic                         malformed_i,
  input  logic                         store_i,
  input  usb_ep_pkg::frame_evt_t       evt_i,
  input  logic                         ack_sent_i,
  input  logic                         rx_error_i,
  input  logic                         resp_i,
  input  logic [usb_ep_pkg::fifo_aw:0] fifo_level_i,
  output logic                         clear_o,
  output logic                         enable_o,
  output logic                         bypass_o,
  output logic                         fifo_save_o,
  output logic                         fifo_drop_o,
  output logic                         stalled_o,
  output logic                         ep_ready_o,
  output logic                         mmio_recv_o
);
  import usb_ep_pkg::*;

  ep_state_e        state;
  logic             enabled_q;
  logic             pending_q;
  logic             pend_end_q;
  logic [fifo_aw:0] fifo_free;
  logic             room;

  // Any configuration event wipes the endpoint
  assign clear_o = set_conf_i | clr_conf_i;

  // Room for one more full frame
  assign fifo_free = (fifo_aw + 1)'(fifo_depth) - fifo_level_i;
  assign room = fifo_free > (fifo_aw + 1)'(max_packet_len);

  assign enable_o = enabled_q && (state != ep_halt);
  assign bypass_o = (state == ep_recv);
  assign stalled_o = (state == ep_halt);

  always_ff @(posedge clock) begin
    if (!rst_n_i || clr_conf_i) begin
      enabled_q <= 1'b0;
    end else if (set_conf_i) begin
      enabled_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i || clear_o) begin
      ep_ready_o <= 1'b0;
    end else begin
      ep_ready_o <= enable_o && room;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i || clear_o) begin
      state       <= ep_idle;
      pending_q   <= 1'b0;
      pend_end_q  <= 1'b0;
      fifo_save_o <= 1'b0;
      fifo_drop_o <= 1'b0;
      mmio_recv_o <= 1'b0;
    end else begin
      fifo_save_o <= 1'b0;
      fifo_drop_o <= 1'b0;
      mmio_recv_o <= 1'b0;
      if (malformed_i) begin
        state <= ep_halt;
      end else begin
        case (state)
          ep_idle: if (store_i) begin
            state     <= ep_recv;
            pending_q <= 1'b0;
          end
          // Frame waits for the USB controller's verdict
          ep_recv: begin
            if (evt_i.last) begin
              pending_q  <= 1'b1;
              pend_end_q <= evt_i.short_frm | evt_i.zdp;
            end else if (pending_q && ack_sent_i) begin
              pending_q   <= 1'b0;
              fifo_save_o <= 1'b1;
              if (pend_end_q) begin
                // Short frame or ZDP closes the data phase
                state       <= ep_resp;
                mmio_recv_o <= 1'b1;
              end
            end else if (pending_q && rx_error_i) begin
              pending_q   <= 1'b0;
              fifo_drop_o <= 1'b1;
            end
          end
          ep_resp: if (resp_i) state <= ep_idle;
          default: state <= ep_halt;
        endcase
      end
    end
  end

endmodule

// ==== mmio_ep_out.sv ====
module mmio_ep_out (
  input  logic                        clock,
  input  logic                        rst_n_i,
  input  logic                        set_conf_i,
  input  logic                        clr_conf_i,
  input  logic [usb_ep_pkg::cnt_w:0]  max_size_i,
  input  logic                        ack_sent_i,
  input  logic                        rx_error_i,
  input  logic                        mmio_resp_i,
  input  logic                        usb_tvalid_i,
  output logic                        usb_tready_o,
  input  logic                        usb_tkeep_i,
  input  logic                        usb_tlast_i,
  input  logic [7:0]                  usb_tdata_i,
  output mmio_cmd_pkg::mmio_cmd_t     cmd_o,
  output logic                        cmd_vld_o,
  input  logic                        cmd_ack_i,
  output logic                        dat_tvalid_o,
  input  logic                        dat_tready_i,
  output logic                        dat_tlast_o,
  output logic [7:0]                  dat_tdata_o,
  output logic                        stalled_o,
  output logic                        ep_ready_o,
  output logic                        mmio_recv_o
);
  import usb_ep_pkg::*;

  frame_evt_t       evt;
  logic             beat;
  logic             clear, enable, bypass;
  logic             parse_tready, fifo_tready, fifo_tvalid;
  logic             fifo_save, fifo_drop;
  logic             malformed, store;
  logic [fifo_aw:0] fifo_level;

  // Parser owns the stream, except during a STORE data phase
  assign usb_tready_o = bypass ? fifo_tready : parse_tready;
  assign beat = usb_tvalid_i && usb_tready_o;

  // ZDP beats carry no byte, keep them out of the FIFO
  assign fifo_tvalid = bypass && usb_tvalid_i && usb_tkeep_i;

  frame_byte_counter u_counter (
    .clock(clock), .rst_n_i(rst_n_i), .clear_i(clear), .beat_i(beat),
    .tkeep_i(usb_tkeep_i), .tlast_i(usb_tlast_i), .max_size_i(max_size_i), .evt_o(evt)
  );

  mmio_cmd_parser u_parser (
    .clock(clock), .rst_n_i(rst_n_i), .clear_i(clear), .enable_i(enable),
    .usb_tdata_i(usb_tdata_i), .evt_i(evt), .tready_o(parse_tready), .cmd_o(cmd_o),
    .cmd_vld_o(cmd_vld_o), .cmd_ack_i(cmd_ack_i), .resp_i(mmio_resp_i),
    .store_o(store), .malformed_o(malformed)
  );

  mmio_ep_ctrl u_ctrl (
    .clock(clock), .rst_n_i(rst_n_i), .set_conf_i(set_conf_i), .clr_conf_i(clr_conf_i),
    .malformed_i(malformed), .store_i(store), .evt_i(evt), .ack_sent_i(ack_sent_i),
    .rx_error_i(rx_error_i), .resp_i(mmio_resp_i), .fifo_level_i(fifo_level),
    .clear_o(clear), .enable_o(enable), .bypass_o(bypass), .fifo_save_o(fifo_save),
    .fifo_drop_o(fifo_drop), .stalled_o(stalled_o), .ep_ready_o(ep_ready_o),
    .mmio_recv_o(mmio_recv_o)
  );

  packet_fifo u_fifo (
    .clock(clock), .rst_n_i(rst_n_i), .clear_i(clear), .s_tvalid_i(fifo_tvalid),
    .s_tready_o(fifo_tready), .s_tlast_i(usb_tlast_i), .s_tdata_i(usb_tdata_i),
    .save_i(fifo_save), .drop_i(fifo_drop), .level_o(fifo_level),
    .m_tvalid_o(dat_tvalid_o), .m_tready_i(dat_tready_i), .m_tlast_o(dat_tlast_o),
    .m_tdata_o(dat_tdata_o)
  );

endmodule

// ==== packet_fifo.sv ====
module packet_fifo (
  input  logic                         clock,
  input  logic                         rst_n_i,
  input  logic                         clear_i,
  input  logic                         s_tvalid_i,
  output logic                         s_tready_o,
  input  logic                         s_tlast_i,
  input  logic [7:0]                   s_tdata_i,
  input  logic                         save_i,
  input  logic                         drop_i,
  output logic [usb_ep_pkg::fifo_aw:0] level_o,
  output logic                         m_tvalid_o,
  input  logic                         m_tready_i,
  output logic                         m_tlast_o,
  output logic [7:0]                   m_tdata_o
);
  import usb_ep_pkg::*;

  // Each entry is {tlast, data}
  logic [8:0]       mem [fifo_depth];
  logic [fifo_aw:0] wr_ptr;
  logic [fifo_aw:0] cm_ptr;
  logic [fifo_aw:0] rd_ptr;
  logic             wr_en;
  logic             rd_en;

  // Level counts uncommitted bytes too, they still take space
  assign level_o = wr_ptr - rd_ptr;
  assign s_tready_o = level_o < (fifo_aw + 1)'(fifo_depth);

  // A drop wins over a byte written in the same cycle
  assign wr_en = s_tvalid_i && s_tready_o && !drop_i;

  // Read side stops at the committed pointer
  assign rd_en = (rd_ptr != cm_ptr) && (!m_tvalid_o || m_tready_i);

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr[fifo_aw-1:0]] <= {s_tlast_i, s_tdata_i};
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i || clear_i) begin
      wr_ptr <= '0;
      cm_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      // Rewind to the last committed frame
      if (drop_i) begin
        wr_ptr <= cm_ptr;
      end else if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // Publish everything written so far
      if (save_i) begin
        cm_ptr <= wr_ptr;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Output register stage
  always_ff @(posedge clock) begin
    if (!rst_n_i || clear_i) begin
      m_tvalid_o <= 1'b0;
    end else if (rd_en) begin
      m_tvalid_o <= 1'b1;
    end else if (m_tready_i) begin
      m_tvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_en) begin
      {m_tlast_o, m_tdata_o} <= mem[rd_ptr[fifo_aw-1:0]];
    end
  end

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clock,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam time half_period = 10ns;

  initial begin
    clock = 1'b0;
    forever #(half_period) clock = ~clock;
  end

  // Reset held low for two rising edges, released just after the second
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clock);
    #2 rst_n_o = 1'b1;
  end

endmodule

// ==== tb_mmio_ep_out.sv ====
module tb_mmio_ep_out;
  timeunit 1ns;
  timeprecision 100ps;
  import usb_ep_pkg::*;
  import mmio_cmd_pkg::*;

  // Cycle budget per test for the watchdog limit
  localparam int t_reset = 20, t_cmd = 100, t_bad = 300, t_store = 200, t_drop = 200;
  localparam int t_bp = 130 * 24 + 400;
  localparam int beat_limit = 64;
  localparam int frame_len = 16;

  logic clock, rst_n_i, set_conf_i, clr_conf_i, ack_sent_i, rx_error_i, mmio_resp_i;
  logic [cnt_w:0] max_size_i;
  logic usb_tvalid_i, usb_tready_o, usb_tkeep_i, usb_tlast_i;
  logic [7:0] usb_tdata_i;
  mmio_cmd_t cmd_o;
  logic cmd_vld_o, cmd_ack_i, dat_tvalid_o, dat_tready_i, dat_tlast_o;
  logic [7:0] dat_tdata_o;
  logic stalled_o, ep_ready_o, mmio_recv_o;

  // Testbench state
  logic [15:0] lfsr = 16'd43;
  logic [1:0] beat_kind;
  logic end_flag, configured, bp_phase;
  logic cmd_end_q, bad_q1, bad_q2, vld_q, stall_q, rdy_q, ack_q, conf_q, conf_q2, end_ack_q;
  mmio_cmd_t exp_cmd;
  logic [8:0] frame_q[$];
  logic [8:0] exp_q[$];
  logic [8:0] got;
  int errors = 0, tests = 0, held = 0, bp_low = 0, test_err;
  string test_name = "reset";
  wire usb_hs = usb_tvalid_i && usb_tready_o;

  tb_clock_gen u_clk (.clock(clock), .rst_n_o(rst_n_i));
  mmio_ep_out dut0 (.*);

  // Fibonacci LFSR with taps 16 14 13 11 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
    errors++;
    $display("MISMATCH %s (%s): expected %h actual %h", test_name, what, exp, act);
  endtask

  // Checkers sampled at the rising edge
  always @(posedge clock) begin
    cmd_end_q <= usb_hs && beat_kind == 2'd1;
    bad_q1 <= usb_hs && beat_kind == 2'd2;
    bad_q2 <= bad_q1;
    vld_q <= cmd_vld_o;
    stall_q <= stalled_o;
    rdy_q <= ep_ready_o;
    ack_q <= cmd_ack_i;
    conf_q <= set_conf_i;
    conf_q2 <= conf_q;
    end_ack_q <= ack_sent_i && end_flag;
    if (rst_n_i) begin
      if (!configured)
        assert ({cmd_vld_o, usb_tready_o, dat_tvalid_o, stalled_o, ep_ready_o, mmio_recv_o} == 0)
        else mismatch("outputs after reset", 0, {cmd_vld_o, usb_tready_o, dat_tvalid_o,
                      stalled_o, ep_ready_o, mmio_recv_o});
      // cmd_vld_o rises one cycle after the closing command byte
      assert ((cmd_vld_o && !vld_q) == cmd_end_q)
      else mismatch("cmd_vld rise", cmd_end_q, cmd_vld_o);
      if (cmd_vld_o && !vld_q)
        assert (cmd_o == exp_cmd) else mismatch("cmd_o", exp_cmd, cmd_o);
      if (ack_q)
        assert (!cmd_vld_o) else mismatch("cmd_vld after ack", 0, cmd_vld_o);
      assert ((stalled_o && !stall_q) == bad_q2)
      else mismatch("stall rise", bad_q2, stalled_o);
      assert (!(stalled_o && usb_tready_o)) else mismatch("tready while stalled", 0, 1);
      if (conf_q)
        assert (!stalled_o) else mismatch("stall after set_conf", 0, 1);
      // ep_ready_o rises two cycles after set_conf_i while the FIFO is empty
      if (conf_q2)
        assert (ep_ready_o && !rdy_q)
        else mismatch("ep_ready rise", 2'b01, {rdy_q, ep_ready_o});
      assert (mmio_recv_o == end_ack_q) else mismatch("mmio_recv", end_ack_q, mmio_recv_o);
      if (dat_tvalid_o && dat_tready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Test %s: output byte %h appeared with nothing expected", test_name,
                   dat_tdata_o);
        end else begin
          got = exp_q.pop_front();
          assert ({dat_tlast_o, dat_tdata_o} == got)
          else mismatch("output byte", got, {dat_tlast_o, dat_tdata_o});
        end
      end
      // Accepted minus delivered bytes never pass the FIFO size plus the output stage
      if (bp_phase) begin
        if (usb_hs)
          assert (held <= fifo_depth) else mismatch("bytes held at accept", fifo_depth, held);
        if (usb_tvalid_i && !usb_tready_o) begin
          bp_low++;
          assert (held >= fifo_depth) else mismatch("tready low with room", fifo_depth, held);
        end
        held <= held + int'(usb_hs && usb_tkeep_i) - int'(dat_tvalid_o && dat_tready_i);
      end
    end
  end

  task automatic send_beat(input logic [7:0] d, input logic keep, input logic last,
                           input logic [1:0] kind);
    int waited;
    logic took;
    waited = 0;
    took = 1'b0;
    usb_tvalid_i = 1'b1;
    usb_tdata_i = d;
    usb_tkeep_i = keep;
    usb_tlast_i = last;
    beat_kind = kind;
    while (!took && waited < beat_limit) begin
      @(negedge clock);
      took = usb_tready_o;
      @(posedge clock);
      waited++;
    end
    #2;
    usb_tvalid_i = 1'b0;
    usb_tkeep_i = 1'b0;
    usb_tlast_i = 1'b0;
    beat_kind = 2'd0;
    if (!took) begin
      errors++;
      $display("Test %s: the DUT never accepted a byte", test_name);
    end
  endtask

  // Bad selects a valid command (0), a wrong magic (1) or tlast on byte 7 (2)
  task automatic send_cmd(input int bad, input logic [1:0] op, input logic dir);
    logic [7:0] b[11];
    int n;
    exp_cmd.lun = 4'(rand_bits(4));
    exp_cmd.adr = 28'(rand_bits(28));
    exp_cmd.len = 16'(rand_bits(16));
    exp_cmd.tag = 4'(rand_bits(4));
    exp_cmd.apb = 1'(rand_bits(1));
    exp_cmd.dir = dir;
    exp_cmd.op = cmd_op_e'(op);
    b[0] = "T";
    b[1] = "A";
    b[2] = "R";
    b[3] = (bad == 1) ? "X" : "T";
    {b[7], b[6], b[5], b[4]} = {exp_cmd.lun, exp_cmd.adr};
    {b[9], b[8]} = exp_cmd.len;
    b[10] = {exp_cmd.tag, dir, exp_cmd.apb, op};
    n = (bad == 1) ? 4 : (bad == 2) ? 8 : 11;
    for (int i = 0; i < n; i++)
      send_beat(b[i], 1'b1, i == n - 1 && bad != 1, i < n - 1 ? 2'd0 : (bad != 0 ? 2'd2 : 2'd1));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clock);
    #2;
  endtask

  // Which selects set_conf (0), cmd_ack (1), ack_sent (2), rx_error (3) or mmio_resp
  task automatic pulse_input(input int which);
    case (which)
      0: set_conf_i = 1'b1;
      1: cmd_ack_i = 1'b1;
      2: ack_sent_i = 1'b1;
      3: rx_error_i = 1'b1;
      default: mmio_resp_i = 1'b1;
    endcase
    wait_cycles(1);
    {set_conf_i, cmd_ack_i, ack_sent_i, rx_error_i, mmio_resp_i, end_flag} = '0;
  endtask

  task automatic configure();
    configured = 1'b1;
    pulse_input(0);
    wait_cycles(3);
  endtask

  task automatic ack_cmd();
    int n;
    n = 0;
    while (n < beat_limit && !cmd_vld_o) begin
      @(negedge clock);
      n++;
    end
    if (!cmd_vld_o) begin
      errors++;
      $display("Test %s: cmd_vld_o never rose", test_name);
    end
    @(posedge clock);
    #2;
    pulse_input(1);
  endtask

  // Zero length sends a ZDP
  task automatic send_frame(input int len);
    logic [7:0] d;
    frame_q.delete();
    if (len == 0) send_beat(8'h00, 1'b0, 1'b1, 2'd0);
    for (int i = 0; i < len; i++) begin
      d = 8'(rand_bits(8));
      frame_q.push_back({i == len - 1, d});
      send_beat(d, 1'b1, i == len - 1, 2'd0);
    end
  endtask

  task automatic verdict(input logic ok, input logic ends);
    if (ok) begin
      foreach (frame_q[i]) exp_q.push_back(frame_q[i]);
      end_flag = ends;
    end
    pulse_input(ok ? 2 : 3);
    wait_cycles(2);
  endtask

  task automatic finish_phase();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 4 * fifo_depth) begin
      @(negedge clock);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Test %s: %0d expected output bytes never arrived", test_name, exp_q.size());
    end
    wait_cycles(1);
    pulse_input(4);
    wait_cycles(2);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("Test %s done with %0d errors", test_name, errors - test_err);
  endtask

  initial begin
    {set_conf_i, clr_conf_i, ack_sent_i, rx_error_i, mmio_resp_i, cmd_ack_i} = '0;
    {usb_tvalid_i, usb_tkeep_i, usb_tlast_i, usb_tdata_i, beat_kind, end_flag} = '0;
    {configured, bp_phase} = '0;
    max_size_i = (cnt_w + 1)'(frame_len);
    dat_tready_i = 1'b1;
    exp_cmd = '0;
    wait (rst_n_i);
    begin_test("reset");
    wait_cycles(t_reset / 2);
    end_test();
    begin_test("command");
    configure();
    send_cmd(0, 2'(rand_bits(2)), 1'b1);
    ack_cmd();
    pulse_input(4);
    wait_cycles(2);
    end_test();
    begin_test("malformed");
    send_cmd(1, 2'd1, 1'b1);
    wait_cycles(6);
    configure();
    send_cmd(2, 2'd2, 1'b1);
    wait_cycles(6);
    configure();
    send_cmd(0, 2'd3, 1'b0);
    ack_cmd();
    pulse_input(4);
    wait_cycles(2);
    end_test();
    begin_test("store");
    send_cmd(0, 2'd0, 1'b0);
    ack_cmd();
    for (int f = 0; f < 3; f++) begin
      send_frame(f < 2 ? frame_len : 5);
      verdict(1'b1, f == 2);
    end
    finish_phase();
    end_test();
    begin_test("drop");
    send_cmd(0, 2'd0, 1'b0);
    ack_cmd();
    send_frame(frame_len);
    verdict(1'b0, 1'b0);
    send_frame(frame_len);
    verdict(1'b1, 1'b0);
    send_frame(0);
    verdict(1'b1, 1'b1);
    finish_phase();
    end_test();
    begin_test("backpressure");
    send_cmd(0, 2'd0, 1'b0);
    ack_cmd();
    dat_tready_i = 1'b0;
    held = 0;
    bp_phase = 1'b1;
    for (int f = 0; f < fifo_depth / frame_len; f++) begin
      send_frame(frame_len);
      verdict(1'b1, 1'b0);
    end
    fork
      send_frame(4);
      begin
        wait_cycles(20);
        dat_tready_i = 1'b1;
      end
    join
    verdict(1'b1, 1'b1);
    finish_phase();
    bp_phase = 1'b0;
    if (bp_low == 0) begin
      errors++;
      $display("Test %s: usb_tready_o never fell with the FIFO full", test_name);
    end
    end_test();
    $display("Tests run %0d, errors %0d", tests, errors);
    if (errors == 0) $display("Simulation PASSED");
    else $display("Simulation FAILED");
    $finish;
  end

  initial begin
    #((t_reset + t_cmd + t_bad + t_store + t_drop + t_bp) * 20ns * 2);
    $display("Watchdog expired before the tests finished");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== usb_ep_pkg.sv ====
package usb_ep_pkg;

  // Largest Bulk-Out frame in bytes (HS mode)
  localparam int unsigned max_packet_len = 512;

  // Packet FIFO capacity in bytes
  localparam int unsigned fifo_depth = 2048;

  // Byte index width, and FIFO pointer width
  localparam int unsigned cnt_w = 10;
  localparam int unsigned fifo_aw = 11;

  // Top-level endpoint phases
  typedef enum logic [1:0] {
    ep_idle = 2'd0,
    ep_recv = 2'd1,
    ep_resp = 2'd2,
    ep_halt = 2'd3
  } ep_state_e;

  // One accepted handshake, as seen by the frame logic
  typedef struct packed {
    logic             beat;
    logic             last;
    logic             short_frm;
    logic             zdp;
    logic [cnt_w-1:0] idx;
  } frame_evt_t;

endpackage
